/* Makefile */
RTL = rtl/rv_core_pkg.sv rtl/rv_fetch.sv rtl/rv_regfile.sv rtl/rv_decode.sv \
      rtl/rv_hazard.sv rtl/rv_execute.sv rtl/rv_mem_access.sv rtl/rv_core.sv

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module rv_core $(RTL)

sim:
	verilator --binary --timing -f rv_core.f --top-module tb_rv_core -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir

/* rtl/rv_core.sv */
//////////////////////////////////////////////////////////////////////
// rv_core
// five-stage RV32I subset core, global stall and stage wiring
//////////////////////////////////////////////////////////////////////
`default_nettype none

module rv_core import rv_core_pkg::*; #(
    parameter word_t reset_pc = 32'h0000_0000
) (
    input  wire logic  clk,
    input  wire logic  rst,
    output word_t      iaddr,
    input  wire word_t idata,
    input  wire logic  iready_n,
    output word_t      daddr,
    output word_t      wdata,
    input  wire word_t rdata,
    output logic       dreq,
    output logic       dwrite,
    input  wire logic  dready_n,
    input  wire logic  dbusy
);

    logic     stall;
    logic     bubble;
    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    reg_wr_t  wr;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     rs1_used;
    logic     rs2_used;
    word_t    rs1_val;
    word_t    rs2_val;

    // only back-pressure in the pipeline
    assign stall = iready_n || (dreq && dready_n) || dbusy;

    rv_fetch #(.reset_pc(reset_pc)) fetch0 (
        .clk(clk), .rst(rst), .stall(stall), .bubble(bubble),
        .iaddr(iaddr), .idata(idata), .if_id(if_id)
    );

    rv_regfile regfile0 (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .wr(wr)
    );

    rv_decode decode0 (
        .clk(clk), .rst(rst), .stall(stall), .bubble(bubble), .if_id(if_id),
        .rs1(rs1), .rs2(rs2), .rs1_used(rs1_used), .rs2_used(rs2_used),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .id_ex(id_ex)
    );

    rv_hazard hazard0 (
        .rs1(rs1), .rs2(rs2), .rs1_used(rs1_used), .rs2_used(rs2_used),
        .id_ex(id_ex), .ex_mem(ex_mem), .bubble(bubble)
    );

    rv_execute execute0 (
        .clk(clk), .rst(rst), .stall(stall), .id_ex(id_ex), .ex_mem(ex_mem)
    );

    rv_mem_access mem_access0 (
        .clk(clk), .rst(rst), .stall(stall), .ex_mem(ex_mem),
        .daddr(daddr), .wdata(wdata), .dreq(dreq), .dwrite(dwrite),
        .rdata(rdata), .dready_n(dready_n), .dbusy(dbusy), .wr(wr)
    );

endmodule

`default_nettype wire

/* rtl/rv_core_pkg.sv */
//////////////////////////////////////////////////////////////////////
// rv_core package
// word and index types, ALU op encoding, pipeline stage registers
// and the RV32I opcode and funct fields of the supported subset
//////////////////////////////////////////////////////////////////////
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_e;

    // major opcodes
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    // lw and sw
    localparam logic [2:0] f3_word = 3'b010;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    // addi x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        alu_op_e  alu_op;
        logic     use_imm;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        word_t    alu_result;
        word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     en;
        reg_idx_t rd;
        word_t    data;
    } reg_wr_t;

endpackage

`default_nettype wire

/* rtl/rv_decode.sv */
//////////////////////////////////////////////////////////////////////
// rv_decode
// instruction fields, immediates, ALU op select, decode-to-execute reg
//////////////////////////////////////////////////////////////////////
`default_nettype none

module rv_decode import rv_core_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     stall,
    input  wire logic     bubble,
    input  wire if_id_t   if_id,
    output reg_idx_t      rs1,
    output reg_idx_t      rs2,
    output logic          rs1_used,
    output logic          rs2_used,
    input  wire word_t    rs1_val,
    input  wire word_t    rs2_val,
    output id_ex_t        id_ex
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f3_alu;
    alu_op_e    f3_op;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    id_ex_t     nxt;

    assign opcode = if_id.instr[6:0];
    assign funct3 = if_id.instr[14:12];
    assign funct7 = if_id.instr[31:25];
    assign rs1    = if_id.instr[19:15];
    assign rs2    = if_id.instr[24:20];

    assign imm_i = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
    assign imm_s = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
    assign imm_u = {if_id.instr[31:12], 12'b0};

    // funct3 to ALU op, shared by register and immediate forms
    always_comb begin
        f3_alu = 1'b1;
        f3_op  = alu_add;
        case (funct3)
            f3_add: f3_op = alu_add;
            f3_slt: f3_op = alu_slt;
            f3_xor: f3_op = alu_xor;
            f3_or:  f3_op = alu_or;
            f3_and: f3_op = alu_and;
            default: f3_alu = 1'b0;
        endcase
    end

    always_comb begin
        nxt          = '0;
        nxt.valid    = if_id.valid;
        nxt.rd       = if_id.instr[11:7];
        nxt.alu_op   = alu_add;
        nxt.rs1_val  = rs1_val;
        nxt.rs2_val  = rs2_val;
        rs1_used     = 1'b0;
        rs2_used     = 1'b0;
        // anything not matched below retires as a no-op
        case (opcode)
            op_lui: begin
                nxt.reg_write = 1'b1;
                nxt.alu_op    = alu_pass_b;
                nxt.use_imm   = 1'b1;
                nxt.imm       = imm_u;
            end
            op_imm: if (f3_alu) begin
                nxt.reg_write = 1'b1;
                nxt.alu_op    = f3_op;
                nxt.use_imm   = 1'b1;
                nxt.imm       = imm_i;
                rs1_used      = 1'b1;
            end
            op_reg: if (f3_alu && (funct7 == f7_base ||
                                   (funct7 == f7_sub && funct3 == f3_add))) begin
                nxt.reg_write = 1'b1;
                nxt.alu_op    = (funct7 == f7_sub) ? alu_sub : f3_op;
                rs1_used      = 1'b1;
                rs2_used      = 1'b1;
            end
            op_load: if (funct3 == f3_word) begin
                nxt.reg_write = 1'b1;
                nxt.mem_read  = 1'b1;
                nxt.use_imm   = 1'b1;
                nxt.imm       = imm_i;
                rs1_used      = 1'b1;
            end
            op_store: if (funct3 == f3_word) begin
                nxt.mem_write = 1'b1;
                nxt.use_imm   = 1'b1;
                nxt.imm       = imm_s;
                rs1_used      = 1'b1;
                rs2_used      = 1'b1;
            end
            default: ;
        endcase
        rs1_used = rs1_used && if_id.valid;
        rs2_used = rs2_used && if_id.valid;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            id_ex.valid <= 1'b0;
        end else if (!stall) begin
            if (bubble) begin
                id_ex.valid <= 1'b0;
            end else begin
                id_ex <= nxt;
            end
        end
    end

    // fetch hands over consecutive words whenever decode consumes one
    a_pc_sequence: assert property (
        @(posedge clk) disable iff (!rst)
        if_id.valid && !stall && !bubble |=> if_id.pc == $past(if_id.pc) + 32'd4
    );

endmodule

`default_nettype wire

/* rtl/rv_execute.sv */
//////////////////////////////////////////////////////////////////////
// rv_execute
// ALU and execute-to-memory register
//////////////////////////////////////////////////////////////////////
`default_nettype none

module rv_execute import rv_core_pkg::*; (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   stall,
    input  wire id_ex_t id_ex,
    output ex_mem_t     ex_mem
);

    word_t op_a;
    word_t op_b;
    word_t result;

    assign op_a = id_ex.rs1_val;
    assign op_b = id_ex.use_imm ? id_ex.imm : id_ex.rs2_val;

    // loads and stores come through as add, giving the address
    always_comb begin
        case (id_ex.alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_and:    result = op_a & op_b;
            alu_or:     result = op_a | op_b;
            alu_xor:    result = op_a ^ op_b;
            alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_pass_b: result = op_b;
            default:    result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ex_mem.valid <= 1'b0;
        end else if (!stall) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.alu_result <= result;
            ex_mem.store_data <= id_ex.rs2_val;
        end
    end

endmodule

`default_nettype wire

/* rtl/rv_fetch.sv */
//////////////////////////////////////////////////////////////////////
// rv_fetch
// program counter, instruction bus address and fetch-to-decode register
//////////////////////////////////////////////////////////////////////
`default_nettype none

module rv_fetch import rv_core_pkg::*; #(
    parameter word_t reset_pc = 32'h0000_0000
) (
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   stall,
    input  wire logic   bubble,
    output word_t       iaddr,
    input  wire word_t  idata,
    output if_id_t      if_id
);

    word_t pc;

    assign iaddr = pc;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc          <= reset_pc;
            if_id.valid <= 1'b0;
        end else if (!stall && !bubble) begin
            // straight-line only, no branch targets
            pc          <= pc + 32'd4;
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= idata;
        end
    end

    // pc word-aligned from reset onwards
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst)
        pc[1:0] == 2'b00
    );

endmodule

`default_nettype wire

/* rtl/rv_hazard.sv */
//////////////////////////////////////////////////////////////////////
// rv_hazard
// read-after-write check against execute and memory stage entries
//////////////////////////////////////////////////////////////////////
`default_nettype none

module rv_hazard import rv_core_pkg::*; (
    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    input  wire logic     rs1_used,
    input  wire logic     rs2_used,
    input  wire id_ex_t   id_ex,
    input  wire ex_mem_t  ex_mem,
    output logic          bubble
);

    logic rs1_pending;
    logic rs2_pending;

    // source still waiting on an in-flight result
    function automatic logic pending(input reg_idx_t src, input logic used,
                                     input id_ex_t ex, input ex_mem_t mem);
        logic ex_hit;
        logic mem_hit;
        ex_hit  = ex.valid && ex.reg_write && ex.rd == src;
        mem_hit = mem.valid && mem.reg_write && mem.rd == src;
        return used && src != '0 && (ex_hit || mem_hit);
    endfunction

    assign rs1_pending = pending(rs1, rs1_used, id_ex, ex_mem);
    assign rs2_pending = pending(rs2, rs2_used, id_ex, ex_mem);

    // write-back stage is covered by regfile write-through
    assign bubble = rs1_pending || rs2_pending;

endmodule

`default_nettype wire

/* rtl/rv_mem_access.sv */
//////////////////////////////////////////////////////////////////////
// rv_mem_access
// data bus master and memory-to-write-back register
//////////////////////////////////////////////////////////////////////
`default_nettype none

module rv_mem_access import rv_core_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    stall,
    input  wire ex_mem_t ex_mem,
    output word_t        daddr,
    output word_t        wdata,
    output logic         dreq,
    output logic         dwrite,
    input  wire word_t   rdata,
    input  wire logic    dready_n,
    input  wire logic    dbusy,
    output reg_wr_t      wr
);

    logic  is_access;
    word_t wb_data;

    assign is_access = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

    // request held for as long as the entry sits in this stage
    assign dreq   = is_access;
    assign dwrite = ex_mem.valid && ex_mem.mem_write;
    assign daddr  = ex_mem.alu_result;
    assign wdata  = ex_mem.store_data;

    // with stall low a pending load has its data on rdata
    assign wb_data = ex_mem.mem_read ? rdata : ex_mem.alu_result;

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr.en <= 1'b0;
        end else if (!stall) begin
            wr.en   <= ex_mem.valid && ex_mem.reg_write;
            wr.rd   <= ex_mem.rd;
            wr.data <= wb_data;
        end
    end

    // an unfinished access must be held by the core-wide stall
    a_req_steady: assert property (
        @(posedge clk) disable iff (!rst)
        dreq && (dready_n || dbusy) |=> dreq && $stable(daddr) && $stable(dwrite)
    );

endmodule

`default_nettype wire

/* rtl/rv_regfile.sv */
//////////////////////////////////////////////////////////////////////
// rv_regfile
// 32 x 32 register file, x0 fixed at zero, write-through on read
//////////////////////////////////////////////////////////////////////
`default_nettype none

module rv_regfile import rv_core_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    output word_t         rs1_val,
    output word_t         rs2_val,
    input  wire reg_wr_t  wr
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // same-cycle write-back wins over the stored value
    assign rs1_val = (wr.en && wr.rd != '0 && wr.rd == rs1) ? wr.data : regs[rs1];
    assign rs2_val = (wr.en && wr.rd != '0 && wr.rd == rs2) ? wr.data : regs[rs2];

endmodule

`default_nettype wire

/* rv_core.f */
rtl/rv_core_pkg.sv
rtl/rv_fetch.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_hazard.sv
rtl/rv_execute.sv
rtl/rv_mem_access.sv
rtl/rv_core.sv
tests/rv_core_checker.sv
tests/tb_rv_core.sv

/* tests/rv_core_checker.sv */
//////////////////////////////////////////////////////////////////////
// rv_core_checker
// in-order model of the program and store-by-store data bus compare
//////////////////////////////////////////////////////////////////////
`default_nettype none

module rv_core_checker import rv_core_pkg::*; #(
    parameter int prog_len = 64
) (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire word_t iaddr,
    input  wire logic  iready_n,
    input  wire logic  dready_n,
    input  wire logic  dbusy,
    input  wire logic  dreq,
    input  wire logic  dwrite,
    input  wire word_t daddr,
    input  wire word_t wdata,
    input  wire word_t prog [prog_len],
    input  wire word_t dmem_init [256]
);

    word_t exp_addr [$];
    word_t exp_data [$];
    string cur_name;
    int    seen;
    int    cur_errors;
    int    tests_run;
    int    tests_failed;
    int    error_count;

    function automatic word_t alu_model(input logic [2:0] f3, input logic sub,
                                        input word_t a, input word_t b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic note_fault(input string msg);
        $display("%s: %s", cur_name, msg);
        cur_errors++;
        error_count++;
    endtask

    task automatic report_mismatch(input string what, input word_t exp, input word_t act);
        $display("[ERROR] %s: %s expected %h actual %h", cur_name, what, exp, act);
        cur_errors++;
        error_count++;
    endtask

    // bus must sit idle at the reset address while reset is held
    task automatic check_reset_bus(input word_t exp_pc);
        if (iaddr !== exp_pc) begin
            report_mismatch("iaddr under reset", exp_pc, iaddr);
        end
        if (dreq !== 1'b0) begin
            report_mismatch("dreq under reset", 32'd0, word_t'(dreq));
        end
    endtask

    task automatic start_test(input string name);
        word_t x [32];
        word_t m [256];
        word_t ins;
        word_t res;
        word_t adr;
        logic  wr;
        cur_name = name;
        cur_errors = 0;
        seen = 0;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++) x[i] = '0;
        for (int i = 0; i < 256; i++) m[i] = dmem_init[i];
        for (int i = 0; i < prog_len; i++) begin
            ins = prog[i];
            wr = 1'b1;
            res = '0;
            case (ins[6:0])
                op_lui: res = {ins[31:12], 12'b0};
                op_imm: res = alu_model(ins[14:12], 1'b0, x[ins[19:15]],
                                        {{20{ins[31]}}, ins[31:20]});
                op_reg: res = alu_model(ins[14:12], ins[30], x[ins[19:15]], x[ins[24:20]]);
                op_load: begin
                    adr = x[ins[19:15]] + {{20{ins[31]}}, ins[31:20]};
                    res = m[adr[9:2]];
                end
                op_store: begin
                    wr = 1'b0;
                    adr = x[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    m[adr[9:2]] = x[ins[24:20]];
                    exp_addr.push_back(adr);
                    exp_data.push_back(x[ins[24:20]]);
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = res;
        end
    endtask

    // a store is done on an edge where nothing holds the pipeline
    always @(posedge clk) begin
        if (rst && dreq && dwrite && !iready_n && !dready_n && !dbusy) begin
            if (seen >= exp_addr.size()) begin
                note_fault($sformatf("unexpected extra store to address %h", daddr));
            end else begin
                if (daddr !== exp_addr[seen]) begin
                    report_mismatch($sformatf("store %0d address", seen),
                                    exp_addr[seen], daddr);
                end
                if (wdata !== exp_data[seen]) begin
                    report_mismatch($sformatf("store %0d data", seen),
                                    exp_data[seen], wdata);
                end
                seen++;
            end
        end
    end

    task automatic finish_test();
        int cycles;
        cycles = 0;
        while (seen < exp_addr.size() && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        if (seen < exp_addr.size()) begin
            note_fault($sformatf("only %0d of %0d stores seen before the timeout",
                                 seen, exp_addr.size()));
        end
        // let trailing no-ops drain to catch stray stores
        cycles = 0;
        while (cycles < 40) begin
            @(posedge clk);
            cycles++;
        end
        tests_run++;
        if (cur_errors != 0) tests_failed++;
        $display("test %s: %s, %0d stores, %0d errors", cur_name,
                 (cur_errors == 0) ? "ok" : "FAIL", seen, cur_errors);
    endtask

endmodule

`default_nettype wire

/* tests/tb_rv_core.sv */
//////////////////////////////////////////////////////////////////////
// tb_rv_core
// random straight-line programs, bus models and test sequence
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_rv_core import rv_core_pkg::*; ();

    localparam word_t start_pc = 32'h0000_0200;
    localparam int    prog_len = 64;
    localparam word_t fill     = 32'h5a3c_96e1;

    logic        clk;
    logic        rst;
    logic        iready_n;
    logic        dready_n;
    logic        dbusy;
    logic        dreq;
    logic        dwrite;
    word_t       iaddr;
    word_t       idata;
    word_t       daddr;
    word_t       wdata;
    word_t       rdata;
    word_t       off;
    word_t       prog [prog_len];
    word_t       dmem [256];
    word_t       dmem_init [256];
    logic        bp_i;
    logic        bp_d;
    logic [31:0] prog_state;
    logic [31:0] hs_state;
    int          plen;

    rv_core #(.reset_pc(start_pc)) dut0 (
        .clk(clk), .rst(rst), .iaddr(iaddr), .idata(idata), .iready_n(iready_n),
        .daddr(daddr), .wdata(wdata), .rdata(rdata), .dreq(dreq), .dwrite(dwrite),
        .dready_n(dready_n), .dbusy(dbusy)
    );

    rv_core_checker #(.prog_len(prog_len)) chk0 (
        .clk(clk), .rst(rst), .iaddr(iaddr), .iready_n(iready_n),
        .dready_n(dready_n), .dbusy(dbusy),
        .dreq(dreq), .dwrite(dwrite), .daddr(daddr), .wdata(wdata),
        .prog(prog), .dmem_init(dmem_init)
    );

    // memory models
    assign off   = (iaddr - start_pc) >> 2;
    assign idata = (off < prog_len) ? prog[off[5:0]] : nop_instr;
    assign rdata = dmem[daddr[9:2]];

    always @(posedge clk) begin
        if (rst && dreq && dwrite && !iready_n && !dready_n && !dbusy) begin
            dmem[daddr[9:2]] <= wdata;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] prog_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], prog_state[0]};
            prog_state = lfsr_next(prog_state);
        end
        return r;
    endfunction

    function automatic logic hs_bit();
        logic b;
        b = hs_state[0];
        hs_state = lfsr_next(hs_state);
        return b;
    endfunction

    // handshake inputs change shortly after each edge
    always @(posedge clk) begin
        #10;
        iready_n = bp_i ? hs_bit() : 1'b0;
        dready_n = bp_d ? hs_bit() : 1'b0;
        dbusy    = bp_d ? (hs_bit() && hs_bit()) : 1'b0;
    end

    function automatic reg_idx_t pick_reg();
        return reg_idx_t'(prog_bits(2) + 32'd1);
    endfunction

    function automatic logic [2:0] pick_f3();
        case (prog_bits(3) % 5)
            0: return f3_add;
            1: return f3_slt;
            2: return f3_xor;
            3: return f3_or;
            default: return f3_and;
        endcase
    endfunction

    function automatic word_t rand_alu(input reg_idx_t rd, input reg_idx_t rs1);
        logic [2:0] kind;
        logic [2:0] f3;
        kind = 3'(prog_bits(3));
        f3 = pick_f3();
        if (kind == 3'd0) return {20'(prog_bits(20)), rd, op_lui};
        if (kind < 3'd4) return {12'(prog_bits(12)), rs1, f3, rd, op_imm};
        if (f3 == f3_add && prog_bits(1) == 32'd1) begin
            return {f7_sub, pick_reg(), rs1, f3_add, rd, op_reg};
        end
        return {f7_base, pick_reg(), rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t enc_lw(input reg_idx_t rd);
        return {2'b00, 8'(prog_bits(8)), 2'b00, 5'd0, f3_word, rd, op_load};
    endfunction

    function automatic word_t enc_sw(input reg_idx_t rs2);
        logic [11:0] imm;
        imm = {2'b00, 8'(prog_bits(8)), 2'b00};
        return {imm[11:5], rs2, 5'd0, f3_word, imm[4:0], op_store};
    endfunction

    task automatic add_instr(input word_t w);
        if (plen < prog_len) begin
            prog[plen] = w;
            plen++;
        end
    endtask

    task automatic build_program(input int mode);
        reg_idx_t a;
        reg_idx_t b;
        int m;
        plen = 0;
        while (plen < prog_len - 4) begin
            m = (mode == 3) ? int'(prog_bits(2) % 3) : mode;
            a = pick_reg();
            b = pick_reg();
            case (m)
                0: begin
                    add_instr(rand_alu(a, pick_reg()));
                    add_instr(enc_sw(a));
                end
                1: begin
                    // write then read at once, then a load-use pair
                    add_instr(rand_alu(a, pick_reg()));
                    add_instr(rand_alu(b, a));
                    add_instr(enc_sw(b));
                    add_instr(enc_lw(a));
                    add_instr(rand_alu(b, a));
                    add_instr(enc_sw(b));
                end
                default: begin
                    add_instr(enc_lw(a));
                    add_instr(enc_sw(a));
                end
            endcase
        end
        while (plen < prog_len) add_instr(nop_instr);
    endtask

    task automatic run_test(input string name, input int mode, input logic regen,
                            input logic bi, input logic bd);
        if (regen) build_program(mode);
        for (int i = 0; i < 256; i++) begin
            dmem_init[i] = word_t'(i << 2) ^ fill;
            dmem[i] = dmem_init[i];
        end
        bp_i = bi;
        bp_d = bd;
        @(posedge clk);
        #10;
        rst = 1'b0;
        chk0.start_test(name);
        for (int c = 0; c < 8; c++) begin
            @(posedge clk);
            #10;
            chk0.check_reset_bus(start_pc);
        end
        rst = 1'b1;
        chk0.finish_test();
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        for (int c = 0; c < 400000; c++) @(posedge clk);
        $display("simulation watchdog expired before the test sequence ended");
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst        = 1'b0;
        iready_n   = 1'b0;
        dready_n   = 1'b0;
        dbusy      = 1'b0;
        bp_i       = 1'b0;
        bp_d       = 1'b0;
        prog_state = 32'h5571;
        hs_state   = 32'h5571;
        run_test("alu_imm", 0, 1'b1, 1'b0, 1'b0);
        run_test("alu_imm_iready", 0, 1'b0, 1'b1, 1'b0);
        run_test("interlock", 1, 1'b1, 1'b0, 1'b0);
        run_test("loads", 2, 1'b1, 1'b0, 1'b0);
        run_test("data_backpressure", 3, 1'b1, 1'b0, 1'b1);
        run_test("reset_state", 3, 1'b1, 1'b1, 1'b1);
        $display("tests run %0d, failed %0d, errors %0d",
                 chk0.tests_run, chk0.tests_failed, chk0.error_count);
        if (chk0.tests_failed == 0 && chk0.error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
